// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
LINTFLAGS = --lint-only -Wall --timing --timescale 1ns/1ns
TOP       = tb_eth_tx
FILELIST  = build.f
PASS_TEXT = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: build.f
+incdir+.
eth_regs_pkg.sv
eth_axi_pkg.sv
eth_tx_regs.sv
eth_tx_fetch.sv
eth_tx_stream.sv
eth_tx_top.sv
eth_tx_sva.sv
tb_eth_tx.sv

// File: eth_axi_pkg.sv
// AXI4 read channel types
// Burst lengths are limited by the size of the burst buffer
`include "eth_tx_macros.svh"

package eth_axi_pkg;

    // Burst length minus one
    typedef logic [`ETH_BURST_BITS-1:0] burst_len_t;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

endpackage

// File: eth_regs_pkg.sv
// Register map types for the transmit DMA
// The descriptor view assumes a ring of 16 entries of 16 bytes each
`include "eth_tx_macros.svh"

package eth_regs_pkg;

    typedef logic [`ETH_PKT_PTR_BITS-1:0] pkt_ptr_t;
    typedef logic [`ETH_SIZE_BITS-1:0] pkt_size_t;
    typedef logic [1:0] byte_lane_t;

    // Register address seen as region and offset
    typedef struct packed {
        logic [1:0] region;
        logic [9:0] offset;
    } reg_global_t;

    // Register address seen as descriptor slot and field
    typedef struct packed {
        logic [1:0] region;
        logic [1:0] unused;
        pkt_ptr_t   index;
        logic [3:0] field;
    } reg_desc_t;

    typedef union packed {
        reg_global_t glob;
        reg_desc_t   desc;
    } reg_addr_t;

endpackage

// File: eth_tx_fetch.sv
// AXI4 read master that fills the burst buffer with one packet's words
// Bursts never cross a 4 KB boundary nor exceed the free buffer space
// Packet lengths of zero are not supported
`timescale 1ns/1ns
`include "eth_tx_macros.svh"

module eth_tx_fetch (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    tx_start,
    input  logic [31:0]             pkt_addr,
    input  eth_regs_pkg::pkt_size_t pkt_size,
    input  eth_axi_pkg::burst_len_t buf_out,
    output logic [31:0]             m_axi_araddr,
    output eth_axi_pkg::burst_len_t m_axi_arlen,
    output logic                    m_axi_arvalid,
    input  logic                    m_axi_arready,
    input  logic [31:0]             m_axi_rdata,
    input  logic                    m_axi_rlast,
    input  eth_axi_pkg::axi_resp_t  m_axi_rresp,
    input  logic                    m_axi_rvalid,
    output logic                    m_axi_rready,
    output logic                    buf_wr,
    output logic [31:0]             buf_wr_data,
    output eth_axi_pkg::burst_len_t buf_inp,
    output logic                    fetch_done,
    output logic                    rd_err
);

    import eth_regs_pkg::*;
    import eth_axi_pkg::*;

    logic        active;
    logic        rd_cyc;
    logic [29:0] word_addr;
    pkt_size_t   word_left;
    burst_len_t  free_len;
    burst_len_t  burst_len;
    burst_len_t  burst_len4k;
    logic        can_issue;

    assign m_axi_rready = rd_cyc;
    assign buf_wr       = rd_cyc && m_axi_rvalid;
    assign buf_wr_data  = m_axi_rdata;

    // One slot stays empty so a full buffer differs from an empty one
    assign free_len = buf_out - buf_inp - 1'b1;

    assign burst_len = (word_left >= pkt_size_t'(free_len)) ? free_len - 1'b1
                                                          : burst_len_t'(word_left) - 1'b1;

    // Complement of the word index is the distance to the 4 KB boundary minus one
    assign burst_len4k = (~word_addr[9:0] >= 10'(burst_len)) ? burst_len
                                                             : ~word_addr[4:0];

    // Wait for a worthwhile burst unless the rest of the packet fits
    assign can_issue = active && !rd_cyc && !fetch_done && free_len != '0 &&
                       (free_len >= burst_len_t'(`ETH_MIN_BURST) ||
                        word_left <= pkt_size_t'(free_len));

    always_ff @(posedge clock) begin
        if (reset) begin
            active        <= 1'b0;
            rd_cyc        <= 1'b0;
            m_axi_arvalid <= 1'b0;
            buf_inp       <= '0;
            fetch_done    <= 1'b0;
            rd_err        <= 1'b0;
        end else if (!tx_start) begin
            active        <= 1'b0;
            rd_cyc        <= 1'b0;
            m_axi_arvalid <= 1'b0;
            buf_inp       <= '0;
            fetch_done    <= 1'b0;
        end else if (!active) begin
            active <= 1'b1;
            rd_err <= 1'b0;
        end else if (rd_cyc) begin
            if (m_axi_arvalid && m_axi_arready) begin
                m_axi_arvalid <= 1'b0;
            end
            if (buf_wr) begin
                buf_inp <= buf_inp + 1'b1;
                if (word_left <= pkt_size_t'(1)) begin
                    fetch_done <= 1'b1;
                end
                if (m_axi_rlast) begin
                    rd_cyc <= 1'b0;
                end
                if (m_axi_rresp != AXI_RESP_OKAY) begin
                    rd_err <= 1'b1;
                end
            end
        end else if (can_issue) begin
            rd_cyc        <= 1'b1;
            m_axi_arvalid <= 1'b1;
        end
    end

    // Word position, count and burst request fields
    always_ff @(posedge clock) begin
        if (tx_start && !active) begin
            word_addr <= pkt_addr[31:2];
            word_left <= pkt_size_t'((15'(pkt_size) + 15'(pkt_addr[1:0]) + 15'd3) >> 2);
        end else if (buf_wr) begin
            word_addr <= word_addr + 1'b1;
            word_left <= word_left - 1'b1;
        end
        if (can_issue) begin
            m_axi_araddr <= {word_addr, 2'b00};
            m_axi_arlen  <= burst_len4k;
        end
    end

endmodule

// File: eth_tx_macros.svh
// Sizing constants and register offsets for the transmit DMA
// The ring holds 2**ETH_PKT_PTR_BITS descriptors
// The burst buffer holds 2**ETH_BURST_BITS words
`ifndef ETH_TX_MACROS_SVH
`define ETH_TX_MACROS_SVH

`define ETH_PKT_PTR_BITS  4
`define ETH_BURST_BITS    5
`define ETH_MIN_BURST     16
`define ETH_REG_ADDR_BITS 12
`define ETH_SIZE_BITS     14

// Byte offsets in the global region
`define ETH_REG_CTRL      10'h000
`define ETH_REG_INT_EN    10'h004
`define ETH_REG_INT_STAT  10'h008
`define ETH_REG_PKT_INP   10'h00c
`define ETH_REG_PKT_OUT   10'h010
`define ETH_REG_ENABLE    10'h014

`define ETH_REGION_GLOBAL 2'd0
`define ETH_REGION_DESC   2'd3

// Field offsets within one descriptor
`define ETH_DESC_ADDR     4'h0
`define ETH_DESC_SIZE     4'h4

`endif

// File: eth_tx_regs.sv
// AXI-Lite register block with the transmit descriptor ring
// Every write gets an OKAY response and unmapped addresses read as zero
`timescale 1ns/1ns
`include "eth_tx_macros.svh"

module eth_tx_regs (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [`ETH_REG_ADDR_BITS-1:0] s_axi_awaddr,
    input  logic                          s_axi_awvalid,
    output logic                          s_axi_awready,
    input  logic [31:0]                   s_axi_wdata,
    input  logic                          s_axi_wvalid,
    output logic                          s_axi_wready,
    output logic [1:0]                    s_axi_bresp,
    output logic                          s_axi_bvalid,
    input  logic                          s_axi_bready,
    input  logic [`ETH_REG_ADDR_BITS-1:0] s_axi_araddr,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,
    output logic [31:0]                   s_axi_rdata,
    output logic [1:0]                    s_axi_rresp,
    output logic                          s_axi_rvalid,
    input  logic                          s_axi_rready,
    output logic                          interrupt,
    input  logic                          tx_axis_tready,
    output logic                          tx_start,
    output logic [31:0]                   pkt_addr,
    output eth_regs_pkg::pkt_size_t       pkt_size,
    input  logic                          fetch_done,
    input  logic                          stream_done,
    input  logic                          rd_err
);

    import eth_regs_pkg::*;

    reg_addr_t   read_addr;
    reg_addr_t   write_addr;
    logic [31:0] write_data;
    logic        rd_req;
    logic [1:0]  wr_req;
    logic        wr_fire;
    logic [31:0] rd_word;

    logic        tx_enable;
    logic        tx_int;
    logic [31:0] int_enable;
    pkt_ptr_t    tx_pkt_inp;
    pkt_ptr_t    tx_pkt_out;
    logic [31:0] tx_addr [1<<`ETH_PKT_PTR_BITS];
    pkt_size_t   tx_size [1<<`ETH_PKT_PTR_BITS];

    // A held response blocks new requests
    assign s_axi_arready = !rd_req && !s_axi_rvalid;
    assign s_axi_awready = !wr_req[0] && !s_axi_bvalid;
    assign s_axi_wready  = !wr_req[1] && !s_axi_bvalid;
    assign wr_fire       = wr_req == 2'b11 && !s_axi_bvalid;
    assign s_axi_rresp   = 2'b00;
    assign s_axi_bresp   = 2'b00;

    assign interrupt = int_enable[0] && tx_int;
    assign pkt_addr  = tx_addr[tx_pkt_out];
    assign pkt_size  = tx_size[tx_pkt_out];

    always_comb begin
        rd_word = '0;
        if (read_addr.glob.region == `ETH_REGION_GLOBAL) begin
            case (read_addr.glob.offset)
                `ETH_REG_CTRL:     rd_word = {29'd0, rd_err, fetch_done, tx_start};
                `ETH_REG_INT_EN:   rd_word = int_enable;
                `ETH_REG_INT_STAT: rd_word = {31'd0, tx_int};
                `ETH_REG_PKT_INP:  rd_word = 32'(tx_pkt_inp);
                `ETH_REG_PKT_OUT:  rd_word = 32'(tx_pkt_out);
                `ETH_REG_ENABLE:   rd_word = {31'd0, tx_enable};
                default:           rd_word = '0;
            endcase
        end else if (read_addr.desc.region == `ETH_REGION_DESC) begin
            case (read_addr.desc.field)
                `ETH_DESC_ADDR: rd_word = tx_addr[read_addr.desc.index];
                `ETH_DESC_SIZE: rd_word = 32'(tx_size[read_addr.desc.index]);
                default:        rd_word = '0;
            endcase
        end
    end

    // Captured request fields, read data and descriptor storage
    always_ff @(posedge clock) begin
        if (s_axi_arready && s_axi_arvalid) begin
            read_addr <= s_axi_araddr;
        end
        if (rd_req && !s_axi_rvalid) begin
            s_axi_rdata <= rd_word;
        end
        if (s_axi_awready && s_axi_awvalid) begin
            write_addr <= s_axi_awaddr;
        end
        if (s_axi_wready && s_axi_wvalid) begin
            write_data <= s_axi_wdata;
        end
        if (wr_fire && write_addr.desc.region == `ETH_REGION_DESC) begin
            if (write_addr.desc.field == `ETH_DESC_ADDR) begin
                tx_addr[write_addr.desc.index] <= write_data;
            end
            if (write_addr.desc.field == `ETH_DESC_SIZE) begin
                tx_size[write_addr.desc.index] <= write_data[`ETH_SIZE_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_req       <= 1'b0;
            wr_req       <= 2'b00;
            s_axi_rvalid <= 1'b0;
            s_axi_bvalid <= 1'b0;
            tx_enable    <= 1'b0;
            tx_int       <= 1'b0;
            int_enable   <= '0;
            tx_pkt_inp   <= '0;
            tx_pkt_out   <= '0;
            tx_start     <= 1'b0;
        end else begin
            if (s_axi_arready && s_axi_arvalid) begin
                rd_req <= 1'b1;
            end
            if (s_axi_rvalid && s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end else if (rd_req && !s_axi_rvalid) begin
                s_axi_rvalid <= 1'b1;
                rd_req       <= 1'b0;
            end
            if (s_axi_awready && s_axi_awvalid) begin
                wr_req[0] <= 1'b1;
            end
            if (s_axi_wready && s_axi_wvalid) begin
                wr_req[1] <= 1'b1;
            end
            if (s_axi_bvalid && s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end else if (wr_fire) begin
                s_axi_bvalid <= 1'b1;
                wr_req       <= 2'b00;
                if (write_addr.glob.region == `ETH_REGION_GLOBAL) begin
                    case (write_addr.glob.offset)
                        `ETH_REG_INT_EN:   int_enable <= write_data;
                        `ETH_REG_INT_STAT: tx_int <= write_data[0];
                        `ETH_REG_PKT_INP:  tx_pkt_inp <= write_data[`ETH_PKT_PTR_BITS-1:0];
                        `ETH_REG_ENABLE:   tx_enable <= write_data[0];
                        default: ;
                    endcase
                end
            end
            // Start when the ring holds a packet and both engines are idle
            if (tx_enable && !tx_start && !fetch_done && !stream_done &&
                tx_pkt_inp != tx_pkt_out && tx_axis_tready) begin
                tx_start <= 1'b1;
            end else if (tx_start && fetch_done && stream_done) begin
                tx_start   <= 1'b0;
                tx_pkt_out <= tx_pkt_out + 1'b1;
                tx_int     <= 1'b1;
            end
        end
    end

endmodule

// File: eth_tx_stream.sv
// Burst buffer and byte unpacker for the transmit byte stream
// Bytes leave little-endian from the start lane given by the packet address
`timescale 1ns/1ns
`include "eth_tx_macros.svh"

module eth_tx_stream (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       tx_start,
    input  logic [31:0]                pkt_addr,
    input  eth_regs_pkg::pkt_size_t    pkt_size,
    input  logic                       buf_wr,
    input  logic [31:0]                buf_wr_data,
    input  logic [`ETH_BURST_BITS-1:0] buf_inp,
    output logic [`ETH_BURST_BITS-1:0] buf_out,
    input  logic                       fetch_done,
    output logic                       stream_done,
    output logic [7:0]                 tx_axis_tdata,
    output logic                       tx_axis_tvalid,
    input  logic                       tx_axis_tready,
    output logic                       tx_axis_tlast
);

    import eth_regs_pkg::*;

    logic [31:0]                burst_buf [1<<`ETH_BURST_BITS];
    logic                       active;
    byte_lane_t                 lane;
    byte_lane_t                 last_lane;
    logic [`ETH_BURST_BITS-1:0] buf_out_next;

    assign buf_out_next   = buf_out + 1'b1;
    assign tx_axis_tvalid = buf_inp != buf_out;
    assign tx_axis_tdata  = burst_buf[buf_out][8*lane +: 8];

    // Final byte sits in the last buffered word once the fetch has finished
    assign tx_axis_tlast = fetch_done && buf_out_next == buf_inp && lane == last_lane;

    always_ff @(posedge clock) begin
        if (buf_wr) begin
            burst_buf[buf_inp] <= buf_wr_data;
        end
    end

    always_ff @(posedge clock) begin
        if (tx_start && !active) begin
            last_lane <= pkt_addr[1:0] + pkt_size[1:0] - 2'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            active      <= 1'b0;
            buf_out     <= '0;
            lane        <= '0;
            stream_done <= 1'b0;
        end else if (!tx_start) begin
            active      <= 1'b0;
            buf_out     <= '0;
            stream_done <= 1'b0;
        end else if (!active) begin
            active <= 1'b1;
            lane   <= pkt_addr[1:0];
        end else if (tx_axis_tvalid && tx_axis_tready) begin
            lane <= lane + 1'b1;
            if (tx_axis_tlast) begin
                buf_out     <= buf_out_next;
                stream_done <= 1'b1;
            end else if (lane == 2'd3) begin
                buf_out <= buf_out_next;
            end
        end
    end

endmodule

// File: eth_tx_sva.sv
// Protocol checks on the AXI4 read channel and the stream outputs
// Only the reset check is active while reset is high
`timescale 1ns/1ns

module eth_tx_sva (
    input logic                    clock,
    input logic                    reset,
    input logic [31:0]             m_axi_araddr,
    input eth_axi_pkg::burst_len_t m_axi_arlen,
    input logic                    m_axi_arvalid,
    input logic                    m_axi_arready,
    input logic                    tx_axis_tvalid,
    input logic                    interrupt
);

    // A pending request keeps its fields until accepted
    ar_hold: assert property (@(posedge clock) disable iff (reset)
        m_axi_arvalid && !m_axi_arready |=>
            m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
        else $error("arvalid or its request fields changed before arready");

    // Last word of the burst stays inside the same 4 KB page
    ar_page: assert property (@(posedge clock) disable iff (reset)
        m_axi_arvalid |-> ({1'b0, m_axi_araddr[11:2]} + 11'(m_axi_arlen)) < 11'h400)
        else $error("read burst crosses a 4 KB boundary");

    reset_idle: assert property (@(posedge clock)
        reset |=> !tx_axis_tvalid && !m_axi_arvalid && !interrupt)
        else $error("tvalid, arvalid or interrupt high after a reset cycle");

endmodule

bind eth_tx_top eth_tx_sva i_eth_tx_sva (
    .clock          (clock),
    .reset          (reset),
    .m_axi_araddr   (m_axi_araddr),
    .m_axi_arlen    (m_axi_arlen),
    .m_axi_arvalid  (m_axi_arvalid),
    .m_axi_arready  (m_axi_arready),
    .tx_axis_tvalid (tx_axis_tvalid),
    .interrupt      (interrupt)
);

// File: eth_tx_top.sv
// Transmit DMA top level
// All ports share one clock and a synchronous active-high reset
`timescale 1ns/1ns
`include "eth_tx_macros.svh"

module eth_tx_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [`ETH_REG_ADDR_BITS-1:0] s_axi_awaddr,
    input  logic                          s_axi_awvalid,
    output logic                          s_axi_awready,
    input  logic [31:0]                   s_axi_wdata,
    input  logic                          s_axi_wvalid,
    output logic                          s_axi_wready,
    output logic [1:0]                    s_axi_bresp,
    output logic                          s_axi_bvalid,
    input  logic                          s_axi_bready,
    input  logic [`ETH_REG_ADDR_BITS-1:0] s_axi_araddr,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,
    output logic [31:0]                   s_axi_rdata,
    output logic [1:0]                    s_axi_rresp,
    output logic                          s_axi_rvalid,
    input  logic                          s_axi_rready,
    output logic [31:0]                   m_axi_araddr,
    output eth_axi_pkg::burst_len_t       m_axi_arlen,
    output logic                          m_axi_arvalid,
    input  logic                          m_axi_arready,
    input  logic [31:0]                   m_axi_rdata,
    input  logic                          m_axi_rlast,
    input  eth_axi_pkg::axi_resp_t        m_axi_rresp,
    input  logic                          m_axi_rvalid,
    output logic                          m_axi_rready,
    output logic                          interrupt,
    output logic [7:0]                    tx_axis_tdata,
    output logic                          tx_axis_tvalid,
    input  logic                          tx_axis_tready,
    output logic                          tx_axis_tlast
);

    import eth_axi_pkg::*;

    logic                      tx_start;
    logic [31:0]               pkt_addr;
    logic [`ETH_SIZE_BITS-1:0] pkt_size;
    logic                      fetch_done;
    logic                      stream_done;
    logic                      rd_err;
    logic                      buf_wr;
    logic [31:0]               buf_wr_data;
    burst_len_t                buf_inp;
    burst_len_t                buf_out;

    eth_tx_regs i_eth_tx_regs (.*);

    eth_tx_fetch i_eth_tx_fetch (.*);

    eth_tx_stream i_eth_tx_stream (.*);

endmodule

// File: tb_eth_tx.sv
// Testbench for the transmit DMA with a randomly delayed AXI4 memory model
// Memory byte at address a is the low byte of a ^ (a >> 8)
`timescale 1ns/1ns
`include "eth_tx_macros.svh"

module tb_eth_tx;

    import eth_regs_pkg::*;
    import eth_axi_pkg::*;

    localparam int CLOCK_PERIOD   = 100;
    localparam int NUM_PACKETS    = 25;
    localparam int MAX_PKT_CYCLES = 2000;

    logic                          clock;
    logic                          reset;
    logic [`ETH_REG_ADDR_BITS-1:0] s_axi_awaddr;
    logic                          s_axi_awvalid;
    logic                          s_axi_awready;
    logic [31:0]                   s_axi_wdata;
    logic                          s_axi_wvalid;
    logic                          s_axi_wready;
    logic [1:0]                    s_axi_bresp;
    logic                          s_axi_bvalid;
    logic                          s_axi_bready;
    logic [`ETH_REG_ADDR_BITS-1:0] s_axi_araddr;
    logic                          s_axi_arvalid;
    logic                          s_axi_arready;
    logic [31:0]                   s_axi_rdata;
    logic [1:0]                    s_axi_rresp;
    logic                          s_axi_rvalid;
    logic                          s_axi_rready;
    logic [31:0]                   m_axi_araddr;
    burst_len_t                    m_axi_arlen;
    logic                          m_axi_arvalid;
    logic                          m_axi_arready;
    logic [31:0]                   m_axi_rdata;
    logic                          m_axi_rlast;
    axi_resp_t                     m_axi_rresp;
    logic                          m_axi_rvalid;
    logic                          m_axi_rready;
    logic                          interrupt;
    logic [7:0]                    tx_axis_tdata;
    logic                          tx_axis_tvalid;
    logic                          tx_axis_tready;
    logic                          tx_axis_tlast;

    logic [31:0] lfsr_state = 32'h1efd_36dc;
    pkt_ptr_t    ring_inp;
    logic [31:0] exp_addr [$];
    int          exp_size [$];

    eth_tx_top i_eth_tx_top (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [7:0] memory_byte(input logic [31:0] addr);
        return addr[7:0] ^ addr[15:8];
    endfunction

    function automatic logic [31:0] memory_word(input logic [31:0] addr);
        logic [31:0] word;
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = memory_byte(addr + 32'(i));
        end
        return word;
    endfunction

    // Reference for byte k of a packet
    function automatic logic [7:0] expected_byte(input logic [31:0] addr, input int k);
        return memory_byte(addr + 32'(k));
    endfunction

    function automatic logic [11:0] global_reg(input logic [9:0] offset);
        return {`ETH_REGION_GLOBAL, offset};
    endfunction

    function automatic logic [11:0] desc_reg(input pkt_ptr_t index, input logic [3:0] field);
        return {`ETH_REGION_DESC, 2'b00, index, field};
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s expected %h got %h", name, expected, actual));
        end
    endtask

    task automatic check_last(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s expected %h got %h", name, expected, actual));
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s expected %h got %h", name, expected, actual));
        end
    endtask

    task automatic check_ptr(input string name, input pkt_ptr_t expected, input pkt_ptr_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s expected %h got %h", name, expected, actual));
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t expected,
                              input axi_resp_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s expected %h got %h", name, expected, actual));
        end
    endtask

    // Ready is sampled on the falling edge, so a high ready means a handshake on the next rise
    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(negedge clock);
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data;
        s_axi_wvalid  = 1'b1;
        while (!aw_done || !w_done) begin
            if (s_axi_awvalid && s_axi_awready) aw_done = 1'b1;
            if (s_axi_wvalid && s_axi_wready) w_done = 1'b1;
            @(negedge clock);
            if (aw_done) s_axi_awvalid = 1'b0;
            if (w_done) s_axi_wvalid = 1'b0;
        end
        while (!s_axi_bvalid) @(negedge clock);
        check_resp("s_axi_bresp", AXI_RESP_OKAY, s_axi_bresp);
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
        @(negedge clock);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        while (!s_axi_arready) @(negedge clock);
        @(negedge clock);
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid) @(negedge clock);
        data = s_axi_rdata;
        check_resp("s_axi_rresp", AXI_RESP_OKAY, s_axi_rresp);
    endtask

    task automatic verify_reg(input string name, input logic [11:0] addr,
                              input logic [31:0] expected);
        logic [31:0] data;
        read_reg(addr, data);
        check_reg(name, expected, data);
    endtask

    task automatic queue_packet(input logic [31:0] addr, input int size);
        write_reg(desc_reg(ring_inp, `ETH_DESC_ADDR), addr);
        write_reg(desc_reg(ring_inp, `ETH_DESC_SIZE), 32'(size));
        exp_addr.push_back(addr);
        exp_size.push_back(size);
        ring_inp = ring_inp + 1'b1;
    endtask

    // Hand the queued descriptors to the DMA and wait until the out pointer catches up
    task automatic send_queued();
        logic [31:0] data;
        write_reg(global_reg(`ETH_REG_PKT_INP), 32'(ring_inp));
        read_reg(global_reg(`ETH_REG_PKT_OUT), data);
        while (data[`ETH_PKT_PTR_BITS-1:0] != ring_inp) begin
            read_reg(global_reg(`ETH_REG_PKT_OUT), data);
        end
        if (exp_addr.size() != 0) begin
            report_failure("ring pointer advanced before all packet bytes were streamed");
        end
        read_reg(global_reg(`ETH_REG_PKT_INP), data);
        check_ptr("tx_pkt_inp", ring_inp, data[`ETH_PKT_PTR_BITS-1:0]);
    endtask

    // AXI4 memory model
    initial begin
        logic [31:0] addr;
        burst_len_t  len;
        logic        accepted;
        m_axi_arready = 1'b0;
        m_axi_rvalid  = 1'b0;
        m_axi_rlast   = 1'b0;
        m_axi_rdata   = '0;
        m_axi_rresp   = AXI_RESP_OKAY;
        forever begin
            @(negedge clock);
            if (m_axi_arvalid) begin
                repeat (random_bits(2)) @(negedge clock);
                addr          = m_axi_araddr;
                len           = m_axi_arlen;
                m_axi_arready = 1'b1;
                @(negedge clock);
                m_axi_arready = 1'b0;
                for (int beat = 0; beat <= int'(len); beat++) begin
                    repeat (random_bits(2)) @(negedge clock);
                    m_axi_rdata  = memory_word(addr + 32'(beat * 4));
                    m_axi_rlast  = beat == int'(len);
                    m_axi_rvalid = 1'b1;
                    accepted     = 1'b0;
                    while (!accepted) begin
                        accepted = m_axi_rready;
                        @(negedge clock);
                    end
                    m_axi_rvalid = 1'b0;
                    m_axi_rlast  = 1'b0;
                end
            end
        end
    end

    // Stream sink with random ready gaps and the byte compare
    initial begin
        int k;
        k = 0;
        tx_axis_tready = 1'b0;
        forever begin
            @(negedge clock);
            tx_axis_tready = reset ? 1'b0 : (random_bits(2) != 32'd0);
            if (tx_axis_tvalid && tx_axis_tready) begin
                if (exp_addr.size() == 0) begin
                    report_failure("stream byte seen while no packet was expected");
                end
                check_byte("tx_axis_tdata", expected_byte(exp_addr[0], k), tx_axis_tdata);
                check_last("tx_axis_tlast", k == exp_size[0] - 1, tx_axis_tlast);
                if (k == exp_size[0] - 1) begin
                    void'(exp_addr.pop_front());
                    void'(exp_size.pop_front());
                    k = 0;
                end else begin
                    k++;
                end
            end
        end
    end

    initial begin
        #(NUM_PACKETS * MAX_PKT_CYCLES * 2 * CLOCK_PERIOD);
        report_failure("timeout waiting for packet completion");
    end

    initial begin
        logic [31:0] data;
        int          lengths [5];
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        ring_inp      = '0;
        reset         = 1'b1;
        repeat (16) @(negedge clock);
        reset = 1'b0;

        // Register read-back
        write_reg(global_reg(`ETH_REG_INT_EN), 32'h5a5a_0000);
        verify_reg("int_enable", global_reg(`ETH_REG_INT_EN), 32'h5a5a_0000);
        write_reg(desc_reg(4'd5, `ETH_DESC_ADDR), 32'h1234_5678);
        verify_reg("tx_addr", desc_reg(4'd5, `ETH_DESC_ADDR), 32'h1234_5678);
        write_reg(desc_reg(4'd5, `ETH_DESC_SIZE), 32'h0000_2abc);
        verify_reg("tx_size", desc_reg(4'd5, `ETH_DESC_SIZE), 32'h0000_2abc);
        write_reg(global_reg(`ETH_REG_ENABLE), 32'd1);
        verify_reg("tx_enable", global_reg(`ETH_REG_ENABLE), 32'd1);
        write_reg(global_reg(`ETH_REG_ENABLE), 32'd0);
        verify_reg("tx_enable", global_reg(`ETH_REG_ENABLE), 32'd0);
        write_reg(global_reg(`ETH_REG_PKT_INP), 32'd9);
        verify_reg("tx_pkt_inp", global_reg(`ETH_REG_PKT_INP), 32'd9);
        write_reg(global_reg(`ETH_REG_PKT_INP), 32'd0);
        read_reg(global_reg(`ETH_REG_PKT_OUT), data);
        check_ptr("tx_pkt_out", '0, data[`ETH_PKT_PTR_BITS-1:0]);
        write_reg(global_reg(`ETH_REG_ENABLE), 32'd1);

        queue_packet(32'h0000_4000, 64);
        send_queued();

        // Unaligned starts with odd lengths
        lengths = '{1, 3, 37, 131, 299};
        for (int lane = 1; lane < 4; lane++) begin
            for (int i = 0; i < 5; i++) begin
                queue_packet(32'h0001_0000 + 32'(lane * 'h4000 + i * 'h400 + lane), lengths[i]);
            end
            send_queued();
        end

        for (int i = 0; i < 6; i++) begin
            queue_packet(32'h0002_0000 + random_bits(18), 1 + int'(random_bits(9)));
        end
        send_queued();

        // Starts 20 bytes below a 4 KB page end
        queue_packet(32'h0000_2fec, 200);
        send_queued();

        // Interrupt masking and clearing
        write_reg(global_reg(`ETH_REG_INT_STAT), 32'd0);
        write_reg(global_reg(`ETH_REG_INT_EN), 32'd1);
        check_reg("interrupt", 32'd0, 32'(interrupt));
        queue_packet(32'h0000_5003, 45);
        send_queued();
        check_reg("interrupt", 32'd1, 32'(interrupt));
        verify_reg("int_status", global_reg(`ETH_REG_INT_STAT), 32'd1);
        write_reg(global_reg(`ETH_REG_INT_STAT), 32'd0);
        check_reg("interrupt", 32'd0, 32'(interrupt));
        write_reg(global_reg(`ETH_REG_INT_EN), 32'd0);
        queue_packet(32'h0000_6002, 10);
        send_queued();
        check_reg("interrupt", 32'd0, 32'(interrupt));
        verify_reg("int_status", global_reg(`ETH_REG_INT_STAT), 32'd1);

        $display("Finished with no errors");
        $finish;
    end

endmodule
